// File: logic/spi_frame_pkg.sv
// SPI command frame layout shared by the receiver, the frame decoder and the scaler
package spi_frame_pkg;

    // one data byte as shifted in on mosi
    typedef logic [7:0] byte_t;

    // byte counter, wide enough to hold FRAME_LEN+1 for overlong frames
    typedef logic [3:0] frame_cnt_t;

    // bytes in a complete command frame
    localparam frame_cnt_t FRAME_LEN = 4'd7;

    // position of each byte inside the frame, in wire order
    typedef enum logic [2:0] {
        POS_MODE  = 3'd0,
        POS_LINT  = 3'd1,
        POS_IDX   = 3'd2,
        POS_RED   = 3'd3,
        POS_GREEN = 3'd4,
        POS_BLUE  = 3'd5,
        POS_WHITE = 3'd6
    } frame_pos_e;

    // lamp mode, bit 0 of the mode byte
    typedef enum logic {
        MODE_DIRECT  = 1'b0,
        MODE_PALETTE = 1'b1
    } lamp_mode_e;

endpackage

// File: logic/color_pkg.sv
// color and PWM definitions: level and duty types, channel count, prescale and palette
package color_pkg;

    typedef logic [7:0]  duty_t;
    typedef logic [7:0]  level_t;
    typedef logic [15:0] product_t;
    typedef logic [2:0]  pal_idx_t;

    // channels in order red, green, blue, white
    localparam int unsigned NUM_CH = 4;

    // clk cycles per PWM counter step, 256 steps -> 1024 clocks per period
    localparam int unsigned PWM_PRESC   = 4;
    localparam int unsigned PWM_PRESC_W = $clog2(PWM_PRESC);

    // one palette entry, element 0 is red (the MSB byte of a 32'hRRGGBBWW literal)
    typedef logic [0:NUM_CH-1][7:0] pal_entry_t;

    localparam pal_entry_t PALETTE [8] = '{
        32'hff_00_00_00,  // red
        32'h00_ff_00_00,  // green
        32'h00_00_ff_00,  // blue
        32'h00_00_00_ff,  // white only
        32'hff_8c_00_40,  // warm amber
        32'h00_ff_ff_00,  // cyan
        32'hff_00_ff_00,  // magenta
        32'h80_80_80_80   // half on all channels
    };

    typedef enum logic [1:0] {IDLE, LOAD, WAIT_MUL, PUBLISH} scaler_state_e;

endpackage

// File: logic/lamp_ifs.sv
// stage-to-stage buses: decoded command (decoder to scaler) and duties (scaler to PWM)
`timescale 1ns/100ps

interface lamp_cmd_if import spi_frame_pkg::*, color_pkg::*; ();
    lamp_mode_e mode;
    byte_t      lint;
    byte_t      idx;
    level_t     red;
    level_t     green;
    level_t     blue;
    level_t     white;
    // one-clock pulse, fields hold until the next one
    logic       cmd_valid;

    modport src (output mode, lint, idx, red, green, blue, white, cmd_valid);
    modport dst (input  mode, lint, idx, red, green, blue, white, cmd_valid);
endinterface

interface duty_if import color_pkg::*; ();
    // per-channel duty, index 0 is red
    duty_t [NUM_CH-1:0] ch;
    // one-clock pulse, ch is stable from here on
    logic               duty_update;

    modport src (output ch, duty_update);
    modport dst (input  ch, duty_update);
endinterface

// File: logic/spi_rx.sv
// SPI mode 0 slave receiver: brings sck/cs_n/mosi into clk, shifts bytes MSB first
`timescale 1ns/100ps

module spi_rx import spi_frame_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  sck,
    input  logic  cs_n,
    input  logic  mosi,
    output byte_t rx_byte,
    output logic  byte_valid,
    output logic  frame_start,
    output logic  frame_end
);

    // two-flop synchronizers plus one delay stage for edge detect
    logic [1:0] sck_sync, cs_sync, mosi_sync;
    logic       sck_d, cs_d;
    logic       sck_rise, cs_fall, cs_rise;
    logic [2:0] bit_cnt_q;
    byte_t      shift_q;

    assign sck_rise = sck_sync[1] & ~sck_d;
    assign cs_fall  = ~cs_sync[1] & cs_d;
    assign cs_rise  = cs_sync[1] & ~cs_d;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            // idle bus levels, so no false edge right after reset
            sck_sync    <= 2'b00;
            cs_sync     <= 2'b11;
            mosi_sync   <= 2'b00;
            sck_d       <= 1'b0;
            cs_d        <= 1'b1;
            bit_cnt_q   <= '0;
            byte_valid  <= 1'b0;
            frame_start <= 1'b0;
            frame_end   <= 1'b0;
        end else begin
            sck_sync    <= {sck_sync[0], sck};
            cs_sync     <= {cs_sync[0], cs_n};
            mosi_sync   <= {mosi_sync[0], mosi};
            sck_d       <= sck_sync[1];
            cs_d        <= cs_sync[1];
            frame_start <= cs_fall;
            frame_end   <= cs_rise;
            byte_valid  <= 1'b0;
            // deselect restarts byte alignment
            if (cs_sync[1]) begin
                bit_cnt_q <= '0;
            end else if (sck_rise) begin
                bit_cnt_q  <= bit_cnt_q + 1'b1;
                byte_valid <= (bit_cnt_q == 3'd7);
            end
        end
    end

    // data shifter, mosi already aligned with the synced sck
    always_ff @(posedge clk) begin
        if (sck_rise && !cs_sync[1]) begin
            shift_q <= {shift_q[6:0], mosi_sync[1]};
        end
    end

    assign rx_byte = shift_q;

endmodule

// File: logic/frame_decoder.sv
// command frame decoder: buffers SPI bytes and commits only exact seven-byte frames
`timescale 1ns/100ps

module frame_decoder import spi_frame_pkg::*; (
    input  logic          clk,
    input  logic          rst_n,
    input  byte_t         rx_byte,
    input  logic          byte_valid,
    input  logic          frame_start,
    input  logic          frame_end,
    lamp_cmd_if.src       cmd
);

    byte_t      frame_buf [FRAME_LEN];
    frame_cnt_t byte_cnt_q;
    logic       commit;

    // exact length only, short and overlong frames are dropped
    assign commit = frame_end && (byte_cnt_q == FRAME_LEN);

    // count saturates one past a full frame
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            byte_cnt_q    <= '0;
            cmd.cmd_valid <= 1'b0;
        end else begin
            cmd.cmd_valid <= commit;
            if (frame_start) begin
                byte_cnt_q <= '0;
            end else if (byte_valid && byte_cnt_q != FRAME_LEN + 1'b1) begin
                byte_cnt_q <= byte_cnt_q + 1'b1;
            end
        end
    end

    // byte buffer, extra bytes past the frame are not stored
    always_ff @(posedge clk) begin
        if (byte_valid && byte_cnt_q < FRAME_LEN) begin
            frame_buf[byte_cnt_q[2:0]] <= rx_byte;
        end
    end

    // command fields, updated together with cmd_valid
    always_ff @(posedge clk) begin
        if (commit) begin
            cmd.mode  <= lamp_mode_e'(frame_buf[POS_MODE][0]);
            cmd.lint  <= frame_buf[POS_LINT];
            cmd.idx   <= frame_buf[POS_IDX];
            cmd.red   <= frame_buf[POS_RED];
            cmd.green <= frame_buf[POS_GREEN];
            cmd.blue  <= frame_buf[POS_BLUE];
            cmd.white <= frame_buf[POS_WHITE];
        end
    end

endmodule

// File: logic/mult8x8.sv
// sequential unsigned 8x8 multiplier, one 8-bit adder, result 9 clocks after ld
`timescale 1ns/100ps

module mult8x8 import color_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     ld,
    input  level_t   a,
    input  duty_t    b,
    output product_t result,
    output logic     mult_rdy
);

    // upper half accumulates, lower half holds the remaining multiplier bits
    product_t   prod_q;
    level_t     mcand_q;
    logic [3:0] step_q;
    logic [8:0] sum;

    // add multiplicand when the current lsb is set
    assign sum = {1'b0, prod_q[15:8]} + (prod_q[0] ? {1'b0, mcand_q} : 9'd0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            step_q   <= '0;
            mult_rdy <= 1'b0;
        end else begin
            mult_rdy <= 1'b0;
            if (ld) begin
                step_q <= 4'd8;
            end else if (step_q != '0) begin
                step_q   <= step_q - 1'b1;
                mult_rdy <= (step_q == 4'd1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ld) begin
            prod_q  <= {8'h00, b};
            mcand_q <= a;
        end else if (step_q != '0) begin
            // shift right with carry from the adder
            prod_q <= {sum, prod_q[7:1]};
        end
    end

    assign result = prod_q;

endmodule

// File: logic/color_scaler.sv
// color scaler: picks direct or palette levels and scales them by intensity in turn
`timescale 1ns/100ps

module color_scaler import spi_frame_pkg::*, color_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    lamp_cmd_if.dst  cmd,
    duty_if.src      duty
);

    scaler_state_e      state_q;
    logic [1:0]         ch_q;
    logic               pending_q;
    duty_t [NUM_CH-1:0] duty_acc;
    level_t             direct_lvl;
    level_t             sel_lvl;
    pal_entry_t         pal;
    logic               ld;
    product_t           mult_result;
    logic               mult_rdy;

    // level for the current channel
    always_comb begin
        case (ch_q)
            2'd0:    direct_lvl = cmd.red;
            2'd1:    direct_lvl = cmd.green;
            2'd2:    direct_lvl = cmd.blue;
            default: direct_lvl = cmd.white;
        endcase
    end

    assign pal     = PALETTE[pal_idx_t'(cmd.idx[2:0])];
    assign sel_lvl = (cmd.mode == MODE_PALETTE) ? pal[ch_q] : direct_lvl;
    assign ld      = (state_q == LOAD);

    mult8x8 i_mult8x8 (
        .clk      (clk),
        .rst_n    (rst_n),
        .ld       (ld),
        .a        (sel_lvl),
        .b        (cmd.lint),
        .result   (mult_result),
        .mult_rdy (mult_rdy)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q          <= IDLE;
            ch_q             <= '0;
            pending_q        <= 1'b0;
            duty.duty_update <= 1'b0;
        end else begin
            duty.duty_update <= 1'b0;
            // remember commands that show up mid-run
            if (cmd.cmd_valid && state_q != IDLE) begin
                pending_q <= 1'b1;
            end
            case (state_q)
                IDLE: if (cmd.cmd_valid) begin
                    ch_q    <= '0;
                    state_q <= LOAD;
                end
                LOAD: state_q <= WAIT_MUL;
                WAIT_MUL: if (mult_rdy) begin
                    ch_q    <= ch_q + 1'b1;
                    state_q <= (ch_q == 2'(NUM_CH - 1)) ? PUBLISH : LOAD;
                end
                PUBLISH: begin
                    duty.duty_update <= 1'b1;
                    ch_q             <= '0;
                    // newest command restarts the walk
                    if (pending_q || cmd.cmd_valid) begin
                        pending_q <= 1'b0;
                        state_q   <= LOAD;
                    end else begin
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // products and published duties
    always_ff @(posedge clk) begin
        if (state_q == WAIT_MUL && mult_rdy) begin
            duty_acc[ch_q] <= mult_result[15:8];
        end
        if (state_q == PUBLISH) begin
            duty.ch <= duty_acc;
        end
    end

endmodule

// File: logic/pwm_gen.sv
// four-channel PWM: prescaled 8-bit counter, shadow duties swapped at period wrap
`timescale 1ns/100ps

module pwm_gen import color_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    duty_if.dst   duty,
    output logic  red,
    output logic  green,
    output logic  blue,
    output logic  white
);

    logic [PWM_PRESC_W-1:0] presc_q;
    logic                   step;
    logic                   wrap;
    duty_t                  cnt_q;
    duty_t [NUM_CH-1:0]     shadow_q;
    logic                   upd_pend_q;
    logic [NUM_CH-1:0]      pin_q;

    // step tick every PWM_PRESC clocks
    assign step = (presc_q == PWM_PRESC_W'(PWM_PRESC - 1));
    assign wrap = step && (cnt_q == 8'hff);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            presc_q    <= '0;
            cnt_q      <= '0;
            shadow_q   <= '0;
            upd_pend_q <= 1'b0;
            pin_q      <= '0;
        end else begin
            presc_q <= step ? '0 : presc_q + 1'b1;
            if (step) begin
                cnt_q <= cnt_q + 1'b1;
            end
            // new duties only at the start of a period
            if (wrap && (upd_pend_q || duty.duty_update)) begin
                shadow_q   <= duty.ch;
                upd_pend_q <= 1'b0;
            end else if (duty.duty_update) begin
                upd_pend_q <= 1'b1;
            end
            // registered comparators
            for (int i = 0; i < NUM_CH; i++) begin
                pin_q[i] <= (cnt_q < shadow_q[i]);
            end
        end
    end

    assign red   = pin_q[0];
    assign green = pin_q[1];
    assign blue  = pin_q[2];
    assign white = pin_q[3];

endmodule

// File: logic/rgbw_lamp.sv
// RGBW lamp controller top: SPI commands in, four PWM lamp pins out
`timescale 1ns/100ps

module rgbw_lamp import spi_frame_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic sck,
    input  logic cs_n,
    input  logic mosi,
    output logic red,
    output logic green,
    output logic blue,
    output logic white
);

    // receiver to decoder strobes
    byte_t rx_byte;
    logic  byte_valid;
    logic  frame_start;
    logic  frame_end;

    lamp_cmd_if cmd_bus ();
    duty_if     duty_bus ();

    spi_rx i_spi_rx (
        .clk         (clk),
        .rst_n       (rst_n),
        .sck         (sck),
        .cs_n        (cs_n),
        .mosi        (mosi),
        .rx_byte     (rx_byte),
        .byte_valid  (byte_valid),
        .frame_start (frame_start),
        .frame_end   (frame_end)
    );

    frame_decoder i_frame_decoder (
        .clk         (clk),
        .rst_n       (rst_n),
        .rx_byte     (rx_byte),
        .byte_valid  (byte_valid),
        .frame_start (frame_start),
        .frame_end   (frame_end),
        .cmd         (cmd_bus.src)
    );

    color_scaler i_color_scaler (
        .clk   (clk),
        .rst_n (rst_n),
        .cmd   (cmd_bus.dst),
        .duty  (duty_bus.src)
    );

    pwm_gen i_pwm_gen (
        .clk   (clk),
        .rst_n (rst_n),
        .duty  (duty_bus.dst),
        .red   (red),
        .green (green),
        .blue  (blue),
        .white (white)
    );

endmodule

// File: dv/rgbw_lamp_tb.sv
// testbench for the RGBW lamp: plays SPI frames from the vectors file and measures pin duties
`timescale 1ns/100ps

module rgbw_lamp_tb import spi_frame_pkg::*, color_pkg::*; ();

    // one line of the data file: ctl, nine frame bytes, four expected duties
    localparam int NUM_VEC     = 26;
    localparam int VEC_BYTES   = 14;
    localparam int MAX_BYTES   = 9;
    localparam int EXP_OFS     = 10;
    localparam int HALF_SCK    = 4;
    localparam int PERIOD_CLKS = 256 * PWM_PRESC;
    // worst case frame: nine bytes, up to 7 idle clocks between bytes, select setup and hold
    localparam int FRAME_CLKS  = MAX_BYTES * (16 * HALF_SCK + 7) + 32;
    localparam int SETTLE_CLKS = 300 + 2 * PERIOD_CLKS;
    localparam int WDOG_CLKS   = NUM_VEC * (FRAME_CLKS + 3500) + 2000;

    logic clk;
    logic rst_n;
    logic sck;
    logic cs_n;
    logic mosi;
    logic red;
    logic green;
    logic blue;
    logic white;

    byte_t       vec_mem [NUM_VEC * VEC_BYTES];
    logic [31:0] lfsr_q;
    int          hi_cnt [NUM_CH];
    int          err_cnt [NUM_CH];
    int          other_err;
    int          check_cnt;
    string       pin_name [NUM_CH] = '{"red", "green", "blue", "white"};

    rgbw_lamp i_rgbw_lamp (
        .clk   (clk),
        .rst_n (rst_n),
        .sck   (sck),
        .cs_n  (cs_n),
        .mosi  (mosi),
        .red   (red),
        .green (green),
        .blue  (blue),
        .white (white)
    );

    // 10 ns clock
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one lfsr step per bit taken
    task automatic random_bits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            val    = (val << 1) | int'(lfsr_q[0]);
        end
    endtask

    // lands 1 ns after the rising edge, where inputs change
    task automatic wait_clks(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    // mode 0, msb first, mosi set while sck is low
    task automatic send_byte(input byte_t b);
        for (int i = 7; i >= 0; i--) begin
            mosi = b[i];
            wait_clks(HALF_SCK);
            sck = 1'b1;
            wait_clks(HALF_SCK);
            sck = 1'b0;
        end
    endtask

    task automatic send_frame(input int base);
        int nbytes;
        int gap;
        nbytes = int'(vec_mem[base][3:0]);
        cs_n   = 1'b0;
        wait_clks(HALF_SCK);
        for (int k = 0; k < nbytes; k++) begin
            send_byte(vec_mem[base + 1 + k]);
            // random idle between bytes
            if (k < nbytes - 1) begin
                random_bits(3, gap);
                wait_clks(gap);
            end
        end
        wait_clks(HALF_SCK);
        cs_n = 1'b1;
        mosi = 1'b0;
        // shortest deselect before the next frame
        wait_clks(HALF_SCK);
    endtask

    // high clocks per pin over one full PWM period, sampled mid-cycle
    task automatic measure_pins();
        logic [NUM_CH-1:0] pins;
        for (int i = 0; i < NUM_CH; i++) begin
            hi_cnt[i] = 0;
        end
        repeat (PERIOD_CLKS) begin
            @(negedge clk);
            pins = {white, blue, green, red};
            for (int i = 0; i < NUM_CH; i++) begin
                if (pins[i]) begin
                    hi_cnt[i]++;
                end
            end
        end
        wait_clks(1);
    endtask

    task automatic check_pin(input int ch, input int exp);
        check_cnt++;
        assert (hi_cnt[ch] == exp) else begin
            $display("ERR t=%0t %s expected %0d seen %0d", $time, pin_name[ch], exp, hi_cnt[ch]);
            err_cnt[ch]++;
        end
    endtask

    initial begin
        int base;
        int err_total;
        rst_n     = 1'b0;
        sck       = 1'b0;
        cs_n      = 1'b1;
        mosi      = 1'b0;
        lfsr_q    = 32'hc466_98e9;
        other_err = 0;
        check_cnt = 0;
        err_total = 0;
        for (int i = 0; i < NUM_CH; i++) begin
            err_cnt[i] = 0;
        end
        // fill first, so a short file leaves bad ctl bytes behind
        for (int i = 0; i < NUM_VEC * VEC_BYTES; i++) begin
            vec_mem[i] = 8'he0 | byte_t'((i ^ (i >> 5)) & 31);
        end
        $readmemh("dv/lamp_vectors.hex", vec_mem);
        wait_clks(10);
        rst_n = 1'b1;
        wait_clks(4);
        // no frame yet, every pin stays low
        measure_pins();
        for (int ch = 0; ch < NUM_CH; ch++) begin
            check_pin(ch, 0);
        end
        for (int v = 0; v < NUM_VEC; v++) begin
            base = v * VEC_BYTES;
            if (vec_mem[base][7:5] != 3'b000 || vec_mem[base][3:0] > 4'd9) begin
                $display("vector %0d has a bad control byte, data file missing or malformed", v);
                other_err++;
            end else begin
                send_frame(base);
                // chained frames go out back to back, only the last one is measured
                if (!vec_mem[base][4]) begin
                    wait_clks(SETTLE_CLKS);
                    measure_pins();
                    for (int ch = 0; ch < NUM_CH; ch++) begin
                        check_pin(ch, int'(vec_mem[base + EXP_OFS + ch]) * int'(PWM_PRESC));
                    end
                end
            end
        end
        for (int i = 0; i < NUM_CH; i++) begin
            err_total += err_cnt[i];
        end
        err_total += other_err;
        $display("checks %0d, errors red %0d green %0d blue %0d white %0d other %0d",
                 check_cnt, err_cnt[0], err_cnt[1], err_cnt[2], err_cnt[3], other_err);
        if (err_total == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // watchdog sized from the vector count
    initial begin
        repeat (WDOG_CLKS) @(posedge clk);
        $display("timeout, the run did not finish within %0d clocks", WDOG_CLKS);
        $display("Test FAILED");
        $finish;
    end

endmodule

// File: dv/lamp_vectors.hex
// ctl (bits 3:0 bytes sent, bit 4 next frame follows at once), frame bytes mode lint idx r g b w x x
// then expected duties red green blue white; each duty is the high byte of level times lint
// direct mode
07 00 ff 00 ff 80 00 40 00 00 fe 7f 00 3f
07 00 80 00 ff 10 c8 01 00 00 7f 08 64 00
07 00 00 00 ff ff ff ff 00 00 00 00 00 00
07 fe ff 07 ff ff ff ff 00 00 fe fe fe fe
07 00 33 00 64 aa 05 f0 00 00 13 21 00 2f
// palette mode, frame levels ignored
07 01 ff 00 12 34 56 78 00 00 fe 00 00 00
07 01 ff 09 ff ff ff ff 00 00 00 fe 00 00
07 01 80 04 00 00 00 00 00 00 7f 46 00 20
07 03 c0 f7 ff 00 ff 00 00 00 60 60 60 60
07 01 40 06 00 00 00 00 00 00 3f 00 3f 00
07 01 ff 05 00 00 00 00 00 00 00 fe fe 00
07 01 ff 02 00 00 00 00 00 00 00 00 fe 00
07 01 ff 03 00 00 00 00 00 00 00 00 00 fe
// short, long and empty frames keep the last duties
06 00 ff 00 ff ff ff 00 00 00 00 00 00 fe
08 00 ff 00 ff ff ff ff 11 00 00 00 00 fe
09 00 ff 00 ff ff ff ff 11 22 00 00 00 fe
00 00 00 00 00 00 00 00 00 00 00 00 00 fe
07 00 ff 00 40 80 c0 20 00 00 3f 7f bf 1f
06 01 ff 00 00 00 00 00 00 00 3f 7f bf 1f
08 01 ff 07 00 00 00 00 00 00 3f 7f bf 1f
// back to back pairs, second frame wins
17 00 ff 00 ff ff ff ff 00 00 fe fe fe fe
07 00 80 00 ff 00 80 c8 00 00 7f 00 40 64
17 01 ff 07 00 00 00 00 00 00 7f 7f 7f 7f
07 00 ff 00 00 00 00 ff 00 00 00 00 00 fe
// rounding edges
07 00 01 00 ff ff ff ff 00 00 00 00 00 00
07 00 ff 00 01 02 fe ff 00 00 00 01 fd fe

// File: sim.f
logic/spi_frame_pkg.sv
logic/color_pkg.sv
logic/lamp_ifs.sv
logic/spi_rx.sv
logic/frame_decoder.sv
logic/mult8x8.sv
logic/color_scaler.sv
logic/pwm_gen.sv
logic/rgbw_lamp.sv
dv/rgbw_lamp_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the RGBW lamp testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module rgbw_lamp_tb -Mdir obj_dir -f sim.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vrgbw_lamp_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^Test OK$"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
